// ==== fpm.f ====
common/fpm_pkg.sv
design/fpm_exp_unit.sv
design/fpm_mant_unit.sv
design/fpm_seq.sv
fpm_regs/fpm_regs.sv
design/fpm_top.sv
bench/fpm_clk_gen.sv
bench/fpm_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -f "$LOG"
verilator --binary --timing -Wno-fatal --top-module fpm_tb -Mdir obj_dir -o fpm_sim \
	-f fpm.f > "$LOG" 2>&1 \
	&& ./obj_dir/fpm_sim >> "$LOG" 2>&1 \
	|| echo "build or run stopped with an error" >> "$LOG"
grep -q "^Result: PASSED$" "$LOG" && echo "simulation passed, see $LOG" && exit 0 \
	|| echo "simulation failed, see $LOG"
exit 1

// ==== bench/fpm_tb.sv ====
// ##############################
// directed tests over AXI4-Lite, inputs change on the rising edge
// outputs are sampled on the falling edge
// ##############################
`timescale 1ns/1ps
`default_nettype none

module fpm_tb;

	import fpm_pkg::*;

	localparam int TMO = 200;

	logic f2strob;
	logic M55_6;
	logic awvalid;
	logic awready;
	axil_aw_t aw;
	logic wvalid;
	logic wready;
	axil_w_t w;
	logic bvalid;
	logic bready;
	logic [1:0] bresp;
	logic arvalid;
	logic arready;
	axil_aw_t ar;
	logic rvalid;
	logic rready;
	axil_r_t r;

	int seed;
	int errors;
	int checks;
	int tests;
	bit aborted;

	fpm_clk_gen fpm_clk_gen_inst (
		.f2strob(f2strob),
		.M55_6(M55_6)
	);

	fpm_top fpm_top_inst (
		.f2strob(f2strob),
		.M55_6(M55_6),
		.awvalid(awvalid),
		.awready(awready),
		.aw(aw),
		.wvalid(wvalid),
		.wready(wready),
		.w(w),
		.bvalid(bvalid),
		.bready(bready),
		.bresp(bresp),
		.arvalid(arvalid),
		.arready(arready),
		.ar(ar),
		.rvalid(rvalid),
		.rready(rready),
		.r(r)
	);

	task automatic note_timeout(input string what);
		$display("timeout at t=%0t: the DUT never gave %s", $time, what);
		aborted = 1'b1;
	endtask

	task automatic check_num(input string name, input fp_num_t got, input fp_num_t want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("FAIL t=%0t %s got exp=%h mant=%h expected exp=%h mant=%h",
				$time, name, got.exp, got.mant, want.exp, want.mant);
		end
	endtask

	task automatic check_flags(input string name, input fpm_flags_t got, input fpm_flags_t want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("FAIL t=%0t %s got cvmz=%b expected cvmz=%b", $time, name, got, want);
		end
	endtask

	task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("FAIL t=%0t %s got %b expected %b", $time, name, got, want);
		end
	endtask

	task automatic check_data(input string name, input logic [AXI_DW-1:0] got,
			input logic [AXI_DW-1:0] want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("FAIL t=%0t %s got %h expected %h", $time, name, got, want);
		end
	endtask

	// hold keeps bready low for that many cycles once bvalid is up
	task automatic bus_write(input logic [AXI_AW-1:0] addr, input logic [AXI_DW-1:0] data,
			input logic [3:0] strb, input int hold, output logic [1:0] resp);
		int n;
		logic aw_rdy;
		logic w_rdy;
		resp = RESP_SLVERR;
		aw_rdy = 1'b0;
		w_rdy = 1'b0;
		if (aborted) begin
			return;
		end
		@(posedge f2strob);
		awvalid <= 1'b1;
		wvalid <= 1'b1;
		aw.addr <= addr;
		w.data <= data;
		w.strb <= strb;
		n = 0;
		do begin
			@(negedge f2strob);
			n++;
			aw_rdy = awready;
			w_rdy = wready;
		end while (!aw_rdy && !w_rdy && n < TMO);
		@(posedge f2strob);
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		if (!aw_rdy && !w_rdy) begin
			note_timeout("awready or wready");
			return;
		end
		if (aw_rdy !== w_rdy) begin
			errors++;
			$display("awready and wready did not pulse together at t=%0t", $time);
		end
		n = 0;
		do begin
			@(negedge f2strob);
			n++;
		end while (!bvalid && n < TMO);
		if (!bvalid) begin
			note_timeout("bvalid");
			return;
		end
		resp = bresp;
		repeat (hold) begin
			@(negedge f2strob);
			if (!bvalid) begin
				errors++;
				$display("bvalid dropped at t=%0t before bready was given", $time);
			end
			check_resp("bresp held", bresp, resp);
		end
		@(posedge f2strob);
		bready <= 1'b1;
		@(posedge f2strob);
		bready <= 1'b0;
	endtask

	task automatic bus_read(input logic [AXI_AW-1:0] addr, input int hold,
			output logic [AXI_DW-1:0] data, output logic [1:0] resp);
		int n;
		logic ar_rdy;
		data = '0;
		resp = RESP_SLVERR;
		ar_rdy = 1'b0;
		if (aborted) begin
			return;
		end
		@(posedge f2strob);
		arvalid <= 1'b1;
		ar.addr <= addr;
		n = 0;
		do begin
			@(negedge f2strob);
			n++;
			ar_rdy = arready;
		end while (!ar_rdy && n < TMO);
		@(posedge f2strob);
		arvalid <= 1'b0;
		if (!ar_rdy) begin
			note_timeout("arready");
			return;
		end
		n = 0;
		do begin
			@(negedge f2strob);
			n++;
		end while (!rvalid && n < TMO);
		if (!rvalid) begin
			note_timeout("rvalid");
			return;
		end
		data = r.data;
		resp = r.resp;
		repeat (hold) begin
			@(negedge f2strob);
			if (!rvalid) begin
				errors++;
				$display("rvalid dropped at t=%0t before rready was given", $time);
			end
			check_data("rdata held", r.data, data);
			check_resp("rresp held", r.resp, resp);
		end
		@(posedge f2strob);
		rready <= 1'b1;
		@(posedge f2strob);
		rready <= 1'b0;
	endtask

	task automatic write_reg(input logic [AXI_AW-1:0] addr, input logic [AXI_DW-1:0] data);
		logic [1:0] resp;
		bus_write(addr, data, 4'hf, 0, resp);
		check_resp("bresp", resp, RESP_OKAY);
	endtask

	task automatic read_reg(input logic [AXI_AW-1:0] addr, output logic [AXI_DW-1:0] data);
		logic [1:0] resp;
		bus_read(addr, 0, data, resp);
		check_resp("rresp", resp, RESP_OKAY);
	endtask

	task automatic write_num(input logic [AXI_AW-1:0] base, input fp_num_t v);
		write_reg(base, {24'h0, v.exp});
		write_reg(base + 8'd4, {24'h0, v.mant[MANT_W-1:32]});
		write_reg(base + 8'd8, v.mant[31:0]);
	endtask

	task automatic read_num(input logic [AXI_AW-1:0] base, output fp_num_t v);
		logic [AXI_DW-1:0] d0;
		logic [AXI_DW-1:0] d1;
		logic [AXI_DW-1:0] d2;
		read_reg(base, d0);
		read_reg(base + 8'd4, d1);
		read_reg(base + 8'd8, d2);
		v.exp = d0[EXP_W-1:0];
		v.mant = {d1[MANT_W-33:0], d2};
	endtask

	task automatic read_status(output logic bsy, output fpm_flags_t fl);
		logic [AXI_DW-1:0] d;
		read_reg(REG_STATUS, d);
		bsy = d[0];
		fl.c = d[4];
		fl.v = d[5];
		fl.m = d[6];
		fl.z = d[7];
	endtask

	task automatic wait_idle();
		int n;
		logic bsy;
		fpm_flags_t fl;
		n = 0;
		bsy = 1'b1;
		while (bsy && n < TMO && !aborted) begin
			read_status(bsy, fl);
			n++;
		end
		if (bsy && !aborted) begin
			note_timeout("busy low in STATUS");
		end
	endtask

	task automatic run_op(input fpm_op_t op, input fp_num_t a, input fp_num_t b,
			output fp_num_t res, output fpm_flags_t fl);
		logic bsy;
		write_num(REG_A_EXP, a);
		write_num(REG_B_EXP, b);
		write_reg(REG_CTRL, {24'h0, 3'b000, 1'b1, 2'b00, op});
		wait_idle();
		read_num(REG_R_EXP, res);
		read_status(bsy, fl);
	endtask

	function automatic fp_num_t make_num(input int e, input logic [MANT_W-1:0] m);
		fp_num_t v;
		v.exp = e[EXP_W-1:0];
		v.mant = m;
		return v;
	endfunction

	// format rules applied step by step on a 41-bit mantissa
	function automatic fp_num_t ref_op(input fpm_op_t op, input fp_num_t a, input fp_num_t b,
			output fpm_flags_t fl);
		int ea;
		int eb;
		int e;
		int sh;
		logic signed [MANT_W:0] ma;
		logic signed [MANT_W:0] mb;
		logic signed [MANT_W:0] s;
		fp_num_t res;
		fl = '0;
		ea = $signed(a.exp);
		eb = $signed(b.exp);
		ma = {a.mant[MANT_W-1], a.mant};
		mb = {b.mant[MANT_W-1], b.mant};
		e = ea;
		if (op == op_add || op == op_sub) begin
			if (ea < eb) begin
				sh = (eb - ea > MANT_W) ? MANT_W : eb - ea;
				ma = ma >>> sh;
				e = eb;
			end else begin
				sh = (ea - eb > MANT_W) ? MANT_W : ea - eb;
				mb = mb >>> sh;
			end
			s = (op == op_sub) ? ma - mb : ma + mb;
			// sum outside [-1, 1) is halved
			if (s[MANT_W] != s[MANT_W-1]) begin
				s = s >>> 1;
				if (e == 127) begin
					fl.v = 1'b1;
				end else begin
					e = e + 1;
				end
			end
		end else begin
			s = ma;
		end
		while (s != 0 && s[MANT_W-1] == s[MANT_W-2] && e > -128) begin
			s = s <<< 1;
			e = e - 1;
		end
		if (s != 0 && s[MANT_W-1] == s[MANT_W-2]) begin
			fl.c = 1'b1;
			s = '0;
		end
		if (s == 0) begin
			e = 0;
		end
		fl.z = (s == 0);
		fl.m = s[MANT_W];
		res.exp = e[EXP_W-1:0];
		res.mant = s[MANT_W-1:0];
		return res;
	endfunction

	task automatic check_op(input string name, input fpm_op_t op, input fp_num_t a,
			input fp_num_t b);
		fp_num_t got;
		fp_num_t want;
		fpm_flags_t gfl;
		fpm_flags_t wfl;
		run_op(op, a, b, got, gfl);
		want = ref_op(op, a, b, wfl);
		check_num(name, got, want);
		check_flags({name, ".flags"}, gfl, wfl);
	endtask

	task automatic end_test(input string name, input int err0);
		tests++;
		if (errors == err0) begin
			$display("%-14s ok", name);
		end else begin
			$display("%-14s %0d errors", name, errors - err0);
		end
	endtask

	task automatic reset_and_regs();
		int err0;
		logic [AXI_DW-1:0] d;
		logic [1:0] resp;
		fp_num_t v;
		err0 = errors;
		read_reg(REG_STATUS, d);
		check_data("STATUS", d, 32'h0);
		read_num(REG_R_EXP, v);
		check_num("R", v, '0);
		write_num(REG_A_EXP, make_num(-127, 40'h12_3456_789a));
		read_num(REG_A_EXP, v);
		check_num("A", v, make_num(-127, 40'h12_3456_789a));
		write_num(REG_B_EXP, make_num(77, 40'hc3_0f0f_a5a5));
		read_num(REG_B_EXP, v);
		check_num("B", v, make_num(77, 40'hc3_0f0f_a5a5));
		write_reg(REG_A_LO, 32'h1122_3344);
		bus_write(REG_A_LO, 32'haabb_ccdd, 4'b1010, 0, resp);
		check_resp("bresp", resp, RESP_OKAY);
		read_reg(REG_A_LO, d);
		check_data("A_LO", d, 32'haa22_cc44);
		write_reg(REG_CTRL, 32'h2);
		read_reg(REG_CTRL, d);
		check_data("CTRL", d, 32'h2);
		read_reg(REG_STATUS, d);
		check_data("STATUS", d, 32'h0);
		end_test("reset_regs", err0);
	endtask

	task automatic add_sub_cases();
		int err0;
		err0 = errors;
		check_op("add_eq", op_add, make_num(3, 40'h40_0000_0000), make_num(3, 40'h20_0000_0000));
		check_op("sub_eq", op_sub, make_num(3, 40'h40_0000_0000), make_num(3, 40'h20_0000_0000));
		check_op("add_ne", op_add, make_num(5, 40'h50_0000_0000), make_num(2, 40'h40_0000_0000));
		check_op("sub_swap", op_sub, make_num(-3, 40'h40_0000_0000),
			make_num(4, 40'ha0_0000_0000));
		check_op("add_d50", op_add, make_num(60, 40'h40_0000_0000),
			make_num(10, 40'h7f_ffff_ffff));
		check_op("add_d80", op_add, make_num(60, 40'h40_0000_0000),
			make_num(-20, 40'h80_0000_0000));
		check_op("sub_d200", op_sub, make_num(-100, 40'h60_0000_0000),
			make_num(100, 40'hc0_0000_0000));
		check_op("sub_zero", op_sub, make_num(7, 40'h40_0000_0000), make_num(7, 40'h40_0000_0000));
		check_op("add_zero", op_add, make_num(0, 40'h30_0000_0000), make_num(0, 40'hd0_0000_0000));
		end_test("add_sub", err0);
	endtask

	task automatic sum_overflow();
		int err0;
		fp_num_t got;
		fpm_flags_t fl;
		err0 = errors;
		// 0.875 + 0.75 = 1.625, halved into 0.8125
		run_op(op_add, make_num(3, 40'h70_0000_0000), make_num(3, 40'h60_0000_0000), got, fl);
		check_num("ovf_r", got, make_num(4, 40'h68_0000_0000));
		check_flags("ovf_f", fl, 4'b0000);
		// at exponent 127 the exponent stays and v is set
		run_op(op_add, make_num(127, 40'h70_0000_0000), make_num(126, 40'h70_0000_0000), got, fl);
		check_num("ovf127_r", got, make_num(127, 40'h54_0000_0000));
		check_flags("ovf127_f", fl, 4'b0100);
		check_op("neg_ovf", op_add, make_num(-5, 40'h80_0000_0000),
			make_num(-5, 40'h80_0000_0000));
		check_op("sub_ovf", op_sub, make_num(10, 40'h70_0000_0000),
			make_num(10, 40'h90_0000_0000));
		end_test("overflow", err0);
	endtask

	task automatic norm_cases();
		int err0;
		fp_num_t got;
		fpm_flags_t fl;
		err0 = errors;
		run_op(op_norm, make_num(20, 40'h08_0000_0000), '0, got, fl);
		check_num("norm3_r", got, make_num(17, 40'h40_0000_0000));
		check_flags("norm3_f", fl, 4'b0000);
		run_op(op_norm, make_num(9, 40'h0), '0, got, fl);
		check_num("zero_r", got, '0);
		check_flags("zero_f", fl, 4'b0001);
		run_op(op_norm, make_num(-126, 40'h01_0000_0000), '0, got, fl);
		check_num("unf_r", got, '0);
		check_flags("unf_f", fl, 4'b1001);
		check_op("norm_lsb", op_norm, make_num(0, 40'h00_0000_0001), '0);
		check_op("norm_neg", op_norm, make_num(5, 40'hff_ffff_ffff), '0);
		check_op("norm_min", op_norm, make_num(-128, 40'h40_0000_0000), '0);
		check_op("norm_op3", fpm_op_t'(2'd3), make_num(2, 40'h10_0000_0000), '0);
		end_test("normalize", err0);
	endtask

	task automatic bus_protocol();
		int err0;
		logic bsy;
		logic [AXI_DW-1:0] d;
		logic [1:0] resp;
		fp_num_t a;
		fp_num_t b;
		fp_num_t got;
		fp_num_t want;
		fpm_flags_t fl;
		fpm_flags_t wfl;
		err0 = errors;
		a = make_num(10, 40'h00_0000_0001);
		b = make_num(10, 40'h40_0000_0000);
		write_num(REG_A_EXP, a);
		write_num(REG_B_EXP, b);
		write_reg(REG_CTRL, {24'h0, 3'b000, 1'b1, 2'b00, op_norm});
		read_status(bsy, fl);
		check_data("STATUS.busy", {31'h0, bsy}, 32'h1);
		// second start lands during the long shift and must be dropped
		write_reg(REG_CTRL, {24'h0, 3'b000, 1'b1, 2'b00, op_add});
		wait_idle();
		read_num(REG_R_EXP, got);
		read_status(bsy, fl);
		want = ref_op(op_norm, a, b, wfl);
		check_num("busy_start_r", got, want);
		check_flags("busy_start_f", fl, wfl);
		check_data("STATUS.busy", {31'h0, bsy}, 32'h0);
		bus_read(8'h40, 0, d, resp);
		check_resp("rresp_40", resp, RESP_SLVERR);
		check_data("rdata_40", d, 32'h0);
		bus_read(8'h06, 0, d, resp);
		check_resp("rresp_06", resp, RESP_SLVERR);
		check_data("rdata_06", d, 32'h0);
		bus_write(8'h80, 32'h1234_5678, 4'hf, 0, resp);
		check_resp("bresp_80", resp, RESP_SLVERR);
		bus_write(REG_B_EXP, 32'h0000_00c5, 4'hf, 3, resp);
		check_resp("bresp_hold", resp, RESP_OKAY);
		bus_read(REG_B_EXP, 4, d, resp);
		check_resp("rresp_hold", resp, RESP_OKAY);
		check_data("rdata_hold", d, 32'h0000_00c5);
		end_test("bus_protocol", err0);
	endtask

	task automatic random_pairs();
		int err0;
		logic [31:0] r1;
		logic [31:0] r2;
		logic [31:0] r3;
		logic [31:0] r4;
		logic [31:0] r5;
		fp_num_t a;
		fp_num_t b;
		fpm_op_t op;
		err0 = errors;
		for (int i = 0; i < 20; i++) begin
			r1 = $random(seed);
			r2 = $random(seed);
			r3 = $random(seed);
			r4 = $random(seed);
			r5 = $random(seed);
			a.exp = r5[7:0];
			a.mant = {r1[7:0], r2};
			b.exp = r5[15:8];
			b.mant = {r3[7:0], r4};
			op = r5[16] ? op_sub : op_add;
			check_op($sformatf("rand%0d", i), op, a, b);
		end
		end_test("random", err0);
	endtask

	initial begin
		int n;
		seed = 4464;
		errors = 0;
		checks = 0;
		tests = 0;
		aborted = 1'b0;
		awvalid = 1'b0;
		aw = '0;
		wvalid = 1'b0;
		w = '0;
		bready = 1'b0;
		arvalid = 1'b0;
		ar = '0;
		rready = 1'b0;
		n = 0;
		while (M55_6 !== 1'b1 && n < TMO) begin
			@(posedge f2strob);
			n++;
		end
		if (M55_6 !== 1'b1) begin
			note_timeout("a reset release");
		end
		reset_and_regs();
		add_sub_cases();
		sum_overflow();
		norm_cases();
		bus_protocol();
		random_pairs();
		$display("tests %0d  checks %0d  errors %0d", tests, checks, errors);
		if (aborted || errors != 0) begin
			$display("Result: FAILED");
		end else begin
			$display("Result: PASSED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== bench/fpm_clk_gen.sv ====
// ##############################
// 40 ns clock, reset low over the first two rising edges
// ##############################
`timescale 1ns/1ps
`default_nettype none

module fpm_clk_gen (
	output logic f2strob,
	output logic M55_6
);

	localparam int HALF_NS = 20;
	localparam int RST_CYCLES = 2;

	initial begin
		f2strob = 1'b0;
		forever #(HALF_NS) f2strob = ~f2strob;
	end

	// release away from the rising edge
	initial begin
		M55_6 = 1'b0;
		repeat (RST_CYCLES) @(posedge f2strob);
		@(negedge f2strob);
		M55_6 = 1'b1;
	end

endmodule

`default_nettype wire

// ==== design/fpm_top.sv ====
// ##############################
// AXI4-Lite register block around the F-PM core
// ##############################
`timescale 1ns/1ps
`default_nettype none

module fpm_top (
	input wire logic f2strob,
	input wire logic M55_6,
	input wire logic awvalid,
	output logic awready,
	input wire fpm_pkg::axil_aw_t aw,
	input wire logic wvalid,
	output logic wready,
	input wire fpm_pkg::axil_w_t w,
	output logic bvalid,
	input wire logic bready,
	output logic [1:0] bresp,
	input wire logic arvalid,
	output logic arready,
	input wire fpm_pkg::axil_aw_t ar,
	output logic rvalid,
	input wire logic rready,
	output fpm_pkg::axil_r_t r
);

	import fpm_pkg::*;

	logic start;
	fpm_op_t op;
	fp_num_t a;
	fp_num_t b;
	logic busy;
	logic done;
	fpm_flags_t flags;
	fpm_ctl_t ctl;
	exp_diff_t diff;
	logic signed [EXP_W-1:0] exp_r;
	logic signed [MANT_W-1:0] mant_r;
	logic mant_norm;
	logic mant_zero;
	logic mant_neg;
	logic add_ovf;
	logic exp_min;
	logic exp_ovf;
	logic exp_unf;

	fpm_regs fpm_regs_inst (
		.f2strob(f2strob),
		.M55_6(M55_6),
		.awvalid(awvalid),
		.awready(awready),
		.aw(aw),
		.wvalid(wvalid),
		.wready(wready),
		.w(w),
		.bvalid(bvalid),
		.bready(bready),
		.bresp(bresp),
		.arvalid(arvalid),
		.arready(arready),
		.ar(ar),
		.rvalid(rvalid),
		.rready(rready),
		.r(r),
		.start(start),
		.op(op),
		.a(a),
		.b(b),
		.busy(busy),
		.done(done),
		.flags(flags),
		.res({exp_r, mant_r})
	);

	fpm_seq fpm_seq_inst (
		.f2strob(f2strob),
		.M55_6(M55_6),
		.start(start),
		.op(op),
		.ctl(ctl),
		.mant_norm(mant_norm),
		.mant_zero(mant_zero),
		.mant_neg(mant_neg),
		.add_ovf(add_ovf),
		.exp_min(exp_min),
		.exp_ovf(exp_ovf),
		.exp_unf(exp_unf),
		.busy(busy),
		.done(done),
		.flags(flags)
	);

	fpm_exp_unit fpm_exp_unit_inst (
		.f2strob(f2strob),
		.M55_6(M55_6),
		.ctl(ctl),
		.a_exp(a.exp),
		.b_exp(b.exp),
		.diff(diff),
		.exp(exp_r),
		.exp_min(exp_min),
		.exp_ovf(exp_ovf),
		.exp_unf(exp_unf)
	);

	fpm_mant_unit fpm_mant_unit_inst (
		.f2strob(f2strob),
		.M55_6(M55_6),
		.ctl(ctl),
		.diff(diff),
		.a_mant(a.mant),
		.b_mant(b.mant),
		.mant(mant_r),
		.mant_norm(mant_norm),
		.mant_zero(mant_zero),
		.mant_neg(mant_neg),
		.add_ovf(add_ovf)
	);

endmodule

`default_nettype wire

// ==== fpm_regs/fpm_regs.sv ====
// ##############################
// one write and one read in flight, no bursts
// unmapped address gives SLVERR, reads 0
// writes to STATUS and R are accepted and dropped
// ##############################
`timescale 1ns/1ps
`default_nettype none

module fpm_regs (
	input wire logic f2strob,
	input wire logic M55_6,
	input wire logic awvalid,
	output logic awready,
	input wire fpm_pkg::axil_aw_t aw,
	input wire logic wvalid,
	output logic wready,
	input wire fpm_pkg::axil_w_t w,
	output logic bvalid,
	input wire logic bready,
	output logic [1:0] bresp,
	input wire logic arvalid,
	output logic arready,
	input wire fpm_pkg::axil_aw_t ar,
	output logic rvalid,
	input wire logic rready,
	output fpm_pkg::axil_r_t r,
	output logic start,
	output fpm_pkg::fpm_op_t op,
	output fpm_pkg::fp_num_t a,
	output fpm_pkg::fp_num_t b,
	input wire logic busy,
	input wire logic done,
	input wire fpm_pkg::fpm_flags_t flags,
	input wire fpm_pkg::fp_num_t res
);

	import fpm_pkg::*;

	fp_num_t res_q;
	fpm_flags_t flags_q;
	logic [AXI_DW-1:0] wr_old;
	logic [AXI_DW-1:0] wr_new;
	logic wr_hit;
	logic [AXI_DW-1:0] rd_val;
	logic rd_hit;

	function automatic logic reg_hit(input logic [AXI_AW-1:0] addr);
		return (addr <= REG_R_LO) && (addr[1:0] == 2'b00);
	endfunction

	function automatic logic [AXI_DW-1:0] reg_rd(input logic [AXI_AW-1:0] addr);
		logic [AXI_DW-1:0] v;
		v = '0;
		case (addr)
		REG_CTRL: v = AXI_DW'(op);
		REG_STATUS: v = AXI_DW'({flags_q.z, flags_q.m, flags_q.v, flags_q.c, 3'b000, busy});
		REG_A_EXP: v = AXI_DW'($unsigned(a.exp));
		REG_A_HI: v = AXI_DW'(a.mant[MANT_W-1:32]);
		REG_A_LO: v = a.mant[31:0];
		REG_B_EXP: v = AXI_DW'($unsigned(b.exp));
		REG_B_HI: v = AXI_DW'(b.mant[MANT_W-1:32]);
		REG_B_LO: v = b.mant[31:0];
		REG_R_EXP: v = AXI_DW'($unsigned(res_q.exp));
		REG_R_HI: v = AXI_DW'(res_q.mant[MANT_W-1:32]);
		REG_R_LO: v = res_q.mant[31:0];
		default: v = '0;
		endcase
		return v;
	endfunction

	function automatic logic [AXI_DW-1:0] merge(input logic [AXI_DW-1:0] old_v,
			input logic [AXI_DW-1:0] new_v, input logic [AXI_DW/8-1:0] strb);
		logic [AXI_DW-1:0] m;
		m = old_v;
		for (int i = 0; i < AXI_DW / 8; i++) begin
			if (strb[i]) begin
				m[8*i +: 8] = new_v[8*i +: 8];
			end
		end
		return m;
	endfunction

	always_comb begin
		wr_hit = reg_hit(aw.addr);
		wr_old = reg_rd(aw.addr);
		wr_new = merge(wr_old, w.data, w.strb);
		rd_hit = reg_hit(ar.addr);
		rd_val = rd_hit ? reg_rd(ar.addr) : '0;
	end

	// write channel, ready pulses once per accepted beat
	always_ff @(posedge f2strob or negedge M55_6) begin
		if (!M55_6) begin
			awready <= 1'b0;
			wready <= 1'b0;
			bvalid <= 1'b0;
			bresp <= RESP_OKAY;
			start <= 1'b0;
			op <= op_add;
			a <= '0;
			b <= '0;
		end else begin
			awready <= awvalid && wvalid && !awready && !bvalid;
			wready <= awvalid && wvalid && !awready && !bvalid;
			start <= 1'b0;
			if (bvalid && bready) begin
				bvalid <= 1'b0;
			end
			if (awready) begin
				bvalid <= 1'b1;
				bresp <= wr_hit ? RESP_OKAY : RESP_SLVERR;
				case (aw.addr)
				REG_CTRL: begin
					op <= fpm_op_t'(wr_new[1:0]);
					start <= w.strb[0] && w.data[4] && !busy;
				end
				REG_A_EXP: a.exp <= wr_new[EXP_W-1:0];
				REG_A_HI: a.mant[MANT_W-1:32] <= wr_new[MANT_W-33:0];
				REG_A_LO: a.mant[31:0] <= wr_new;
				REG_B_EXP: b.exp <= wr_new[EXP_W-1:0];
				REG_B_HI: b.mant[MANT_W-1:32] <= wr_new[MANT_W-33:0];
				REG_B_LO: b.mant[31:0] <= wr_new;
				default: begin
				end
				endcase
			end
		end
	end

	// read channel, data held until rready
	always_ff @(posedge f2strob or negedge M55_6) begin
		if (!M55_6) begin
			arready <= 1'b0;
			rvalid <= 1'b0;
			r <= '0;
		end else begin
			arready <= arvalid && !arready && !rvalid;
			if (rvalid && rready) begin
				rvalid <= 1'b0;
			end
			if (arready) begin
				rvalid <= 1'b1;
				r.data <= rd_val;
				r.resp <= rd_hit ? RESP_OKAY : RESP_SLVERR;
			end
		end
	end

	always_ff @(posedge f2strob or negedge M55_6) begin
		if (!M55_6) begin
			res_q <= '0;
			flags_q <= '0;
		end else if (done) begin
			res_q <= res;
			flags_q <= flags;
		end
	end

endmodule

`default_nettype wire

// ==== design/fpm_seq.sv ====
// ##############################
// one op at a time, start is dropped while busy
// busy also covers the done cycle
// ##############################
`timescale 1ns/1ps
`default_nettype none

module fpm_seq (
	input wire logic f2strob,
	input wire logic M55_6,
	input wire logic start,
	input wire fpm_pkg::fpm_op_t op,
	output fpm_pkg::fpm_ctl_t ctl,
	input wire logic mant_norm,
	input wire logic mant_zero,
	input wire logic mant_neg,
	input wire logic add_ovf,
	input wire logic exp_min,
	input wire logic exp_ovf,
	input wire logic exp_unf,
	output logic busy,
	output logic done,
	output fpm_pkg::fpm_flags_t flags
);

	import fpm_pkg::*;

	typedef enum logic [2:0] {
		S_IDLE,
		S_LOAD,
		S_ALIGN,
		S_ADD,
		S_OVF,
		S_NORM,
		S_FINISH
	} state_t;

	state_t state;
	state_t state_nx;
	fpm_op_t op_q;
	logic is_norm;

	assign is_norm = (op_q != op_add) && (op_q != op_sub);
	assign busy = (state != S_IDLE) || done;

	always_comb begin
		ctl = '0;
		state_nx = state;
		case (state)
		S_IDLE: begin
			if (start) begin
				state_nx = S_LOAD;
			end
		end
		S_LOAD: begin
			ctl.load = 1'b1;
			state_nx = is_norm ? S_NORM : S_ALIGN;
		end
		S_ALIGN: begin
			ctl.align = 1'b1;
			state_nx = S_ADD;
		end
		S_ADD: begin
			ctl.add = (op_q == op_add);
			ctl.sub = (op_q == op_sub);
			state_nx = S_OVF;
		end
		S_OVF: begin
			ctl.ovf_shift = add_ovf;
			state_nx = S_NORM;
		end
		S_NORM: begin
			// one left shift per cycle until normalized
			if (mant_zero) begin
				ctl.zero_res = 1'b1;
				state_nx = S_FINISH;
			end else if (mant_norm) begin
				state_nx = S_FINISH;
			end else if (exp_min) begin
				// underflow, shift marks unf, result goes to zero
				ctl.norm_shift = 1'b1;
				ctl.zero_res = 1'b1;
				state_nx = S_FINISH;
			end else begin
				ctl.norm_shift = 1'b1;
			end
		end
		S_FINISH: begin
			state_nx = S_IDLE;
		end
		default: begin
			state_nx = S_IDLE;
		end
		endcase
	end

	always_ff @(posedge f2strob or negedge M55_6) begin
		if (!M55_6) begin
			state <= S_IDLE;
			op_q <= op_add;
			done <= 1'b0;
			flags <= '0;
		end else begin
			state <= state_nx;
			done <= (state == S_FINISH);
			if (state == S_IDLE && start) begin
				op_q <= op;
			end
			if (state == S_FINISH) begin
				flags.c <= exp_unf;
				flags.v <= exp_ovf;
				flags.m <= mant_neg;
				flags.z <= mant_zero;
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/fpm_mant_unit.sv ====
// ##############################
// alignment truncates shifted-out bits, no rounding
// sum is held on 41 bits until the overflow shift
// ##############################
`timescale 1ns/1ps
`default_nettype none

module fpm_mant_unit (
	input wire logic f2strob,
	input wire logic M55_6,
	input wire fpm_pkg::fpm_ctl_t ctl,
	input wire fpm_pkg::exp_diff_t diff,
	input wire logic signed [fpm_pkg::MANT_W-1:0] a_mant,
	input wire logic signed [fpm_pkg::MANT_W-1:0] b_mant,
	output logic signed [fpm_pkg::MANT_W-1:0] mant,
	output logic mant_norm,
	output logic mant_zero,
	output logic mant_neg,
	output logic add_ovf
);

	import fpm_pkg::*;

	logic signed [MANT_W-1:0] ma_q;
	logic signed [MANT_W-1:0] mb_q;
	logic signed [MANT_W:0] acc;
	logic [MANT_W:0] ma_x;
	logic [MANT_W:0] mb_x;
	logic [MANT_W:0] sum;

	// one adder, sub inverts b and feeds the carry in
	always_comb begin
		ma_x = {ma_q[MANT_W-1], ma_q};
		mb_x = {mb_q[MANT_W-1], mb_q};
		if (ctl.sub) begin
			mb_x = ~mb_x;
		end
		sum = ma_x + mb_x + {{MANT_W{1'b0}}, ctl.sub};
	end

	// operand copies, the smaller exponent side gets aligned
	always_ff @(posedge f2strob) begin
		if (ctl.load) begin
			ma_q <= a_mant;
			mb_q <= b_mant;
		end else if (ctl.align) begin
			if (diff.swap) begin
				ma_q <= ma_q >>> diff.shamt;
			end else begin
				mb_q <= mb_q >>> diff.shamt;
			end
		end
	end

	always_ff @(posedge f2strob or negedge M55_6) begin
		if (!M55_6) begin
			acc <= '0;
		end else if (ctl.zero_res) begin
			acc <= '0;
		end else if (ctl.load) begin
			// op_norm works on A directly
			acc <= {a_mant[MANT_W-1], a_mant};
		end else if (ctl.add || ctl.sub) begin
			acc <= sum;
		end else if (ctl.ovf_shift) begin
			acc <= acc >>> 1;
		end else if (ctl.norm_shift) begin
			acc <= {acc[MANT_W-2], acc[MANT_W-2:0], 1'b0};
		end
	end

	assign mant = acc[MANT_W-1:0];
	assign mant_norm = acc[MANT_W-1] ^ acc[MANT_W-2];
	assign mant_zero = (acc == '0);
	assign mant_neg = acc[MANT_W];
	// true sign sits in bit 40 after an add
	assign add_ovf = acc[MANT_W] ^ acc[MANT_W-1];

endmodule

`default_nettype wire

// ==== design/fpm_exp_unit.sv ====
// ##############################
// exponent saturates at 127 (v) and -128 (c)
// ovf and unf are sticky until the next load
// ##############################
`timescale 1ns/1ps
`default_nettype none

module fpm_exp_unit (
	input wire logic f2strob,
	input wire logic M55_6,
	input wire fpm_pkg::fpm_ctl_t ctl,
	input wire logic signed [fpm_pkg::EXP_W-1:0] a_exp,
	input wire logic signed [fpm_pkg::EXP_W-1:0] b_exp,
	output fpm_pkg::exp_diff_t diff,
	output logic signed [fpm_pkg::EXP_W-1:0] exp,
	output logic exp_min,
	output logic exp_ovf,
	output logic exp_unf
);

	import fpm_pkg::*;

	logic signed [EXP_W:0] d_full;
	logic [EXP_W:0] d_abs;
	exp_diff_t diff_d;
	logic signed [EXP_W-1:0] b_exp_q;

	// signed difference a - b, one extra bit so it never wraps
	always_comb begin
		d_full = {a_exp[EXP_W-1], a_exp} - {b_exp[EXP_W-1], b_exp};
		d_abs = d_full[EXP_W] ? -d_full : d_full;
		diff_d.swap = d_full[EXP_W];
		if (d_abs >= MANT_W) begin
			diff_d.shamt = SHAMT_W'(MANT_W);
		end else begin
			diff_d.shamt = d_abs[SHAMT_W-1:0];
		end
	end

	assign exp_min = (exp == EXP_MIN);

	always_ff @(posedge f2strob) begin
		if (ctl.load) begin
			b_exp_q <= b_exp;
		end
	end

	// working exponent starts as A, takes B on align when B is larger
	always_ff @(posedge f2strob or negedge M55_6) begin
		if (!M55_6) begin
			diff <= '0;
			exp <= '0;
		end else if (ctl.load) begin
			diff <= diff_d;
			exp <= a_exp;
		end else if (ctl.zero_res) begin
			exp <= '0;
		end else if (ctl.align) begin
			if (diff.swap) begin
				exp <= b_exp_q;
			end
		end else if (ctl.ovf_shift) begin
			if (exp != EXP_MAX) begin
				exp <= exp + 1'b1;
			end
		end else if (ctl.norm_shift) begin
			if (!exp_min) begin
				exp <= exp - 1'b1;
			end
		end
	end

	always_ff @(posedge f2strob or negedge M55_6) begin
		if (!M55_6) begin
			exp_ovf <= 1'b0;
			exp_unf <= 1'b0;
		end else if (ctl.load) begin
			exp_ovf <= 1'b0;
			exp_unf <= 1'b0;
		end else begin
			if (ctl.ovf_shift && exp == EXP_MAX) begin
				exp_ovf <= 1'b1;
			end
			if (ctl.norm_shift && exp_min) begin
				exp_unf <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== common/fpm_pkg.sv ====
// ##############################
// number: 8-bit exponent, 40-bit fraction in [-1, 1)
// normalized when mant[39] != mant[38], zero is all zero
// AXI4-Lite is 32-bit data, 8-bit byte address
// ##############################
`default_nettype none

package fpm_pkg;

	localparam int EXP_W = 8;
	localparam int MANT_W = 40;
	localparam int SHAMT_W = 6;
	localparam int AXI_AW = 8;
	localparam int AXI_DW = 32;

	localparam logic signed [EXP_W-1:0] EXP_MAX = 8'sd127;
	localparam logic signed [EXP_W-1:0] EXP_MIN = -8'sd128;

	typedef struct packed {
		logic signed [EXP_W-1:0] exp;
		logic signed [MANT_W-1:0] mant;
	} fp_num_t;

	// 2'b11 is reserved and runs as op_norm
	typedef enum logic [1:0] {
		op_add = 2'd0,
		op_sub = 2'd1,
		op_norm = 2'd2
	} fpm_op_t;

	typedef struct packed {
		logic c;
		logic v;
		logic m;
		logic z;
	} fpm_flags_t;

	typedef struct packed {
		logic load;
		logic align;
		logic add;
		logic sub;
		logic ovf_shift;
		logic norm_shift;
		logic zero_res;
	} fpm_ctl_t;

	typedef struct packed {
		logic swap;
		logic [SHAMT_W-1:0] shamt;
	} exp_diff_t;

	localparam logic [AXI_AW-1:0] REG_CTRL = 8'h00;
	localparam logic [AXI_AW-1:0] REG_STATUS = 8'h04;
	localparam logic [AXI_AW-1:0] REG_A_EXP = 8'h08;
	localparam logic [AXI_AW-1:0] REG_A_HI = 8'h0c;
	localparam logic [AXI_AW-1:0] REG_A_LO = 8'h10;
	localparam logic [AXI_AW-1:0] REG_B_EXP = 8'h14;
	localparam logic [AXI_AW-1:0] REG_B_HI = 8'h18;
	localparam logic [AXI_AW-1:0] REG_B_LO = 8'h1c;
	localparam logic [AXI_AW-1:0] REG_R_EXP = 8'h20;
	localparam logic [AXI_AW-1:0] REG_R_HI = 8'h24;
	localparam logic [AXI_AW-1:0] REG_R_LO = 8'h28;

	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	typedef struct packed {
		logic [AXI_AW-1:0] addr;
	} axil_aw_t;

	typedef struct packed {
		logic [AXI_DW-1:0] data;
		logic [AXI_DW/8-1:0] strb;
	} axil_w_t;

	typedef struct packed {
		logic [AXI_DW-1:0] data;
		logic [1:0] resp;
	} axil_r_t;

endpackage

`default_nettype wire
